/* filelist.f */
+incdir+verification
source/riscv_pkg.sv
source/fetch_unit.sv
source/register_file.sv
source/decode_stage.sv
source/forwarding_unit.sv
source/execute_stage.sv
source/riscv_core.sv
verification/riscv_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module riscv_core_tb -Mdir obj_dir

./obj_dir/Vriscv_core_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "tests failed" sim.log; then
    echo "FAIL"
    exit 1
fi
if grep -qx "all tests passed" sim.log; then
    echo "PASS"
    exit 0
fi
echo "no result in sim.log"
exit 1

/* source/decode_stage.sv */
module decode_stage
    import riscv_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  logic            fetch_valid,
    input  logic [XLEN-1:0] fetch_pc,
    input  logic [XLEN-1:0] instruction,
    input  logic            flush,
    input  wb_t             wb,
    output id_ex_t          id_ex
);

    opcode_e                   opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [REG_ADDR_WIDTH-1:0] rd_addr;
    logic [XLEN-1:0]           rs1_data;
    logic [XLEN-1:0]           rs2_data;
    logic [XLEN-1:0]           imm_i;
    logic [XLEN-1:0]           imm_u;
    logic [XLEN-1:0]           imm_b;
    logic                      op_legal;
    logic                      op_imm_legal;
    alu_op_e                   alu_base;
    id_ex_t                    dec;

    assign opcode   = opcode_e'(instruction[6:0]);
    assign funct3   = instruction[14:12];
    assign funct7   = instruction[31:25];
    assign rd_addr  = instruction[11:7];
    assign rs1_addr = instruction[19:15];
    assign rs2_addr = instruction[24:20];

    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_u = {instruction[31:12], 12'b0};
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};

    // Only add/sub and srl/sra accept the alternate funct7
    assign op_legal     = (funct7 == '0) ||
                          (funct7 == FUNCT7_ALT && (funct3 == 3'b000 || funct3 == 3'b101));
    assign op_imm_legal = (funct3 == 3'b001) ? (funct7 == '0) :
                          (funct3 == 3'b101) ? (funct7 == '0 || funct7 == FUNCT7_ALT) : 1'b1;

    always_comb begin
        case (funct3)
            3'b000:  alu_base = ALU_ADD;
            3'b001:  alu_base = ALU_SLL;
            3'b010:  alu_base = ALU_SLT;
            3'b011:  alu_base = ALU_SLTU;
            3'b100:  alu_base = ALU_XOR;
            3'b101:  alu_base = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_base = ALU_OR;
            default: alu_base = ALU_AND;
        endcase
    end

    register_file u_register_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    always_comb begin
        dec          = '0;
        dec.valid    = fetch_valid;
        dec.pc       = fetch_pc;
        dec.rs1_addr = rs1_addr;
        dec.rs2_addr = rs2_addr;
        dec.rs1_data = rs1_data;
        dec.rs2_data = rs2_data;
        dec.rd       = rd_addr;
        dec.imm      = imm_i;
        dec.alu_op   = ALU_ADD;
        dec.branch   = BR_NONE;
        // Anything not matched below stays a no-op without write-back
        case (opcode)
            OPC_OP: begin
                dec.alu_op = (funct3 == 3'b000 && funct7[5]) ? ALU_SUB : alu_base;
                dec.rd_we  = op_legal && rd_addr != '0;
            end
            OPC_OP_IMM: begin
                dec.alu_op  = alu_base;
                dec.use_imm = 1'b1;
                dec.rd_we   = op_imm_legal && rd_addr != '0;
            end
            OPC_LUI: begin
                dec.imm     = imm_u;
                dec.alu_op  = ALU_PASS_B;
                dec.use_imm = 1'b1;
                dec.rd_we   = rd_addr != '0;
            end
            OPC_BRANCH: begin
                dec.imm = imm_b;
                if (funct3 == 3'b000) dec.branch = BR_EQ;
                if (funct3 == 3'b001) dec.branch = BR_NE;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else begin
            id_ex <= dec;
            // Killed by a taken branch in execute
            if (flush) id_ex.valid <= 1'b0;
        end
    end

endmodule

/* source/execute_stage.sv */
module execute_stage
    import riscv_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  id_ex_t          id_ex,
    input  logic [XLEN-1:0] rs1_value,
    input  logic [XLEN-1:0] rs2_value,
    output redirect_t       redirect,
    output wb_t             wb
);

    logic [XLEN-1:0]        op_a;
    logic [XLEN-1:0]        op_b;
    logic [SHAMT_WIDTH-1:0] shamt;
    logic [XLEN-1:0]        alu_result;
    logic                   operands_equal;
    logic                   branch_cond;

    assign op_a  = rs1_value;
    assign op_b  = id_ex.use_imm ? id_ex.imm : rs2_value;
    assign shamt = op_b[SHAMT_WIDTH-1:0];

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SLT:    alu_result = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_result = XLEN'(op_a < op_b);
            ALU_SLL:    alu_result = op_a << shamt;
            ALU_SRL:    alu_result = op_a >> shamt;
            ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    ////////////////////////////////////////
    // Branch resolution
    ////////////////////////////////////////

    // Branches compare the two registers and use imm only for the target
    assign operands_equal = (rs1_value == rs2_value);

    always_comb begin
        case (id_ex.branch)
            BR_EQ:   branch_cond = operands_equal;
            BR_NE:   branch_cond = !operands_equal;
            default: branch_cond = 1'b0;
        endcase
    end

    assign redirect.taken  = id_ex.valid && branch_cond;
    assign redirect.target = id_ex.pc + id_ex.imm;

    ////////////////////////////////////////
    // Write-back register
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb <= '0;
        end else begin
            wb.valid <= id_ex.valid && id_ex.rd_we;
            wb.rd    <= id_ex.rd;
            wb.data  <= alu_result;
        end
    end

    // Decode flush must leave a bubble right behind every taken branch
    a_redirect_bubble : assert property (
        @(posedge clk) disable iff (!arst_n)
        redirect.taken |=> !id_ex.valid
    ) else $error("taken branch not followed by a flushed slot");

endmodule

/* source/fetch_unit.sv */
module fetch_unit
    import riscv_pkg::*;
(
    input  logic            clk,
    input  logic            arst_n,
    input  redirect_t       redirect,
    output logic [XLEN-1:0] imem_addr,
    output logic            fetch_valid,
    output logic [XLEN-1:0] fetch_pc
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;

    // Taken branch overrides the sequential step
    assign pc_next   = redirect.taken ? redirect.target : pc + XLEN'(4);
    assign imem_addr = pc;

    ////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc          <= RESET_PC;
            fetch_valid <= 1'b0;
        end else begin
            pc          <= pc_next;
            // Word fetched on the wrong path is dropped
            fetch_valid <= !redirect.taken;
        end
    end

    // Travels alongside the memory read, arrives with imem_data
    always_ff @(posedge clk) begin
        fetch_pc <= pc;
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    a_imem_addr_aligned : assert property (
        @(posedge clk) disable iff (!arst_n)
        imem_addr[1:0] == 2'b00
    ) else $error("fetch address not word aligned");

endmodule

/* source/forwarding_unit.sv */
module forwarding_unit
    import riscv_pkg::*;
(
    input  id_ex_t          id_ex,
    input  wb_t             wb,
    output logic [XLEN-1:0] rs1_value,
    output logic [XLEN-1:0] rs2_value
);

    logic rs1_hit;
    logic rs2_hit;

    ////////////////////////////////////////
    // Bypass from write-back
    ////////////////////////////////////////

    // The producer one instruction ahead is in the wb register now;
    // older producers were already caught by the register file write-through
    assign rs1_hit = wb.valid && (wb.rd == id_ex.rs1_addr);
    assign rs2_hit = wb.valid && (wb.rd == id_ex.rs2_addr);

    assign rs1_value = rs1_hit ? wb.data : id_ex.rs1_data;
    assign rs2_value = rs2_hit ? wb.data : id_ex.rs2_data;

endmodule

/* source/register_file.sv */
module register_file
    import riscv_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [REG_ADDR_WIDTH-1:0] rs1_addr,
    input  logic [REG_ADDR_WIDTH-1:0] rs2_addr,
    output logic [XLEN-1:0]           rs1_data,
    output logic [XLEN-1:0]           rs2_data,
    input  wb_t                       wb
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Write-through so a same-cycle write is seen by decode
    assign rs1_data = (rs1_addr == '0)                 ? '0      :
                      (wb.valid && wb.rd == rs1_addr) ? wb.data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0)                 ? '0      :
                      (wb.valid && wb.rd == rs2_addr) ? wb.data : regs[rs2_addr];

    // Execute must never retire a write to x0
    a_no_x0_write : assert property (
        @(posedge clk) disable iff (!arst_n)
        wb.valid |-> wb.rd != '0
    ) else $error("write-back targets x0");

endmodule

/* source/riscv_core.sv */
module riscv_core
    import riscv_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n,

    // Instruction memory, data returned one cycle after the address
    output logic [XLEN-1:0]           imem_addr,
    input  logic [XLEN-1:0]           imem_data,

    // Retired register writes
    output logic                      wb_valid,
    output logic [REG_ADDR_WIDTH-1:0] wb_rd,
    output logic [XLEN-1:0]           wb_data
);

    // Fetch --> decode
    logic            fetch_valid;
    logic [XLEN-1:0] fetch_pc;

    // Decode --> forwarding / execute
    id_ex_t          id_ex;

    // Forwarding --> execute
    logic [XLEN-1:0] rs1_value;
    logic [XLEN-1:0] rs2_value;

    // Execute --> fetch / decode / forwarding / outputs
    redirect_t       redirect;
    wb_t             wb;

    ////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .redirect    (redirect),
        .imem_addr   (imem_addr),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc)
    );

    decode_stage u_decode_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .instruction (imem_data),
        .flush       (redirect.taken),
        .wb          (wb),
        .id_ex       (id_ex)
    );

    forwarding_unit u_forwarding_unit (
        .id_ex     (id_ex),
        .wb        (wb),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    execute_stage u_execute_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .id_ex     (id_ex),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .redirect  (redirect),
        .wb        (wb)
    );

    assign wb_valid = wb.valid;
    assign wb_rd    = wb.rd;
    assign wb_data  = wb.data;

endmodule

/* source/riscv_pkg.sv */
package riscv_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int XLEN           = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int NUM_REGS       = 32;
    localparam int SHAMT_WIDTH    = 5;

    localparam logic [XLEN-1:0] RESET_PC   = '0;

    // funct7 that selects sub and sra/srai
    localparam logic [6:0]      FUNCT7_ALT = 7'b0100000;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } branch_e;

    ////////////////////////////////////////
    // Pipeline payloads
    ////////////////////////////////////////

    typedef struct packed {
        logic                      valid;
        logic [XLEN-1:0]           pc;
        logic [REG_ADDR_WIDTH-1:0] rs1_addr;
        logic [REG_ADDR_WIDTH-1:0] rs2_addr;
        logic [XLEN-1:0]           rs1_data;
        logic [XLEN-1:0]           rs2_data;
        logic [XLEN-1:0]           imm;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic                      rd_we;
        alu_op_e                   alu_op;
        logic                      use_imm;
        branch_e                   branch;
    } id_ex_t;

    typedef struct packed {
        logic                      valid;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [XLEN-1:0]           data;
    } wb_t;

    typedef struct packed {
        logic                      taken;
        logic [XLEN-1:0]           target;
    } redirect_t;

endpackage

/* verification/riscv_ref_model.svh */
`ifndef RISCV_REF_MODEL_SVH
`define RISCV_REF_MODEL_SVH

////////////////////////////////////////
// Program image and expected writes
////////////////////////////////////////

localparam int PROG_LEN  = 64;
localparam int MEM_WORDS = 256;

// beq x0, x0, 0
localparam logic [XLEN-1:0] SELF_LOOP = 32'h0000_0063;

typedef struct packed {
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [XLEN-1:0]           data;
} reg_write_t;

integer          seed = 32'he6aa_a639;
logic [XLEN-1:0] imem [MEM_WORDS];
reg_write_t      expected_writes [$];

function automatic logic [31:0] pick(input logic [31:0] n);
    return $unsigned($random(seed)) % n;
endfunction

function automatic logic [31:0] encode_r(input logic [2:0] f3, input logic alt,
                                         input logic [4:0] rd, rs1, rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] encode_i(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic logic [31:0] encode_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
endfunction

function automatic logic [31:0] encode_branch(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                              input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

// Integer ALU by funct3, alt selects sub and sra
function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'b0, $signed(a) < $signed(b)};
        3'd3:    return {31'b0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

task automatic generate_program();
    int          i;
    int          r;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    for (i = 0; i < MEM_WORDS; i++) begin
        imem[8'(i)] = '0;
    end
    // Setup of x1..x7 with lui/addi pairs
    for (r = 1; r < 8; r++) begin
        imem[8'(2 * r - 2)] = encode_lui(5'(r), 20'($random(seed)));
        imem[8'(2 * r - 1)] = encode_i(3'b000, 5'(r), 5'(r), 12'($random(seed)));
    end
    // Small register window keeps dependencies frequent
    for (i = 14; i < PROG_LEN - 1; i++) begin
        f3  = 3'(pick(8));
        alt = 1'(pick(2));
        if (pick(8) == 0 && i + 4 < PROG_LEN) begin
            // Forward branch skipping one to three instructions
            imem[8'(i)] = encode_branch({2'b0, alt}, 5'(pick(8)), 5'(pick(8)),
                                        13'((2 + pick(3)) * 4));
        end else if (pick(2) == 0) begin
            imem[8'(i)] = encode_r(f3, alt && (f3 == 3'd0 || f3 == 3'd5),
                                   5'(pick(8)), 5'(pick(8)), 5'(pick(8)));
        end else begin
            imm = 12'($random(seed));
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm = {1'b0, alt && f3 == 3'd5, 5'b0, imm[4:0]};
            end
            imem[8'(i)] = encode_i(f3, 5'(pick(8)), 5'(pick(8)), imm);
        end
    end
    imem[8'(PROG_LEN - 1)] = SELF_LOOP;
endtask

// Sequential ISA model, collects every write to x1..x31 in program order
task automatic run_model();
    logic [XLEN-1:0] regs [NUM_REGS];
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm_b;
    logic [2:0]      f3;
    logic            taken;
    reg_write_t      entry;
    int              r;
    int              steps;
    for (r = 0; r < NUM_REGS; r++) begin
        regs[5'(r)] = '0;
    end
    pc    = RESET_PC;
    inst  = imem[pc[9:2]];
    steps = 0;
    while (inst != SELF_LOOP && steps < PROG_LEN) begin
        f3         = inst[14:12];
        a          = regs[inst[19:15]];
        b          = regs[inst[24:20]];
        imm_b      = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        taken      = 1'b0;
        entry.rd   = inst[11:7];
        entry.data = '0;
        case (inst[6:0])
            7'b0110011: entry.data = alu_model(f3, inst[30], a, b);
            7'b0010011: entry.data = alu_model(f3, inst[30] && f3 == 3'd5, a,
                                               {{20{inst[31]}}, inst[31:20]});
            7'b0110111: entry.data = {inst[31:12], 12'b0};
            7'b1100011: begin
                entry.rd = '0;
                taken    = (f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b);
            end
            default:    entry.rd = '0;
        endcase
        if (entry.rd != '0) begin
            regs[entry.rd] = entry.data;
            expected_writes.push_back(entry);
        end
        pc    = taken ? pc + imm_b : pc + 32'd4;
        inst  = imem[pc[9:2]];
        steps++;
    end
endtask

`endif

/* verification/riscv_core_tb.sv */
module riscv_core_tb
    import riscv_pkg::*;
();

    `include "riscv_ref_model.svh"

    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 3 * PROG_LEN + 50;
    // Fetch runs straight for at least this long since the first branch sits past the setup
    localparam int STARTUP_CHECKS = 8;
    localparam logic [XLEN-1:0] LOOP_ADDR = XLEN'((PROG_LEN - 1) * 4);

    logic                      clk;
    logic                      arst_n    = 1'b0;
    logic [XLEN-1:0]           imem_addr;
    logic [XLEN-1:0]           imem_data = '0;
    logic                      wb_valid;
    logic [REG_ADDR_WIDTH-1:0] wb_rd;
    logic [XLEN-1:0]           wb_data;

    int unsigned cycle_count        = 0;
    int unsigned cycles_after_reset = 0;
    int unsigned writes_checked     = 0;
    reg_write_t  next_write;

    riscv_core DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Instruction memory with one cycle of read latency
    always @(posedge clk) begin
        imem_data <= imem[imem_addr[9:2]];
    end

    task automatic report_mismatch(input string test_name,
                                   input logic [XLEN-1:0] expected, actual);
        $display("error: %s expected %h actual %h", test_name, expected, actual);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (arst_n) begin
            if (cycles_after_reset < STARTUP_CHECKS) begin
                assert (imem_addr == XLEN'(cycles_after_reset * 4))
                    else report_mismatch("startup fetch address",
                                         XLEN'(cycles_after_reset * 4), imem_addr);
            end
            if (cycles_after_reset < 3) begin
                assert (!wb_valid)
                    else report_failure("write-back strobe within three cycles of reset");
            end
            if (wb_valid) begin
                assert (wb_rd != '0)
                    else report_failure("write-back to register x0");
                assert (expected_writes.size() != 0)
                    else report_failure("write-back after the last expected register write");
                next_write = expected_writes.pop_front();
                assert (wb_rd == next_write.rd)
                    else report_mismatch($sformatf("write %0d rd", writes_checked),
                                         XLEN'(next_write.rd), XLEN'(wb_rd));
                assert (wb_data == next_write.data)
                    else report_mismatch($sformatf("write %0d data", writes_checked),
                                         next_write.data, wb_data);
                writes_checked++;
            end
            cycles_after_reset++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout after %0d cycles, program did not finish",
                                     cycle_count));
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        generate_program();
        run_model();
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        while (expected_writes.size() != 0) begin
            @(posedge clk);
        end
        while (imem_addr != LOOP_ADDR) begin
            @(posedge clk);
        end
        // A few turns of the self-loop so a stray write-back still shows up
        repeat (12) @(posedge clk);
        // Checks of the last edge have run by now
        @(negedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule
